//--- common/spiPkg.sv
//--------------------
// Shared constants for the SPI master block
// Offsets are 8 bit, matched against the low address field
// Receive data sits apart from the write registers at 0x80
//--------------------
package spiPkg;

	//--------------------
	// Data widths
	//--------------------
	// One SPI word, MSB first on the wire
	localparam int cDataWidth = 8;

	// USI read and write data word
	localparam int cUsiDataWidth = 32;

	// Bit counter inside the sequencer
	// Wide enough for eight bit positions
	localparam int cBitCntWidth = 3;

	//--------------------
	// Register offsets
	//--------------------
	// Enable, bit 0 only, cleared by the end of transfer
	localparam logic [7:0] cOfsEn = 8'h00;

	// SCK divider, half period is value plus one
	localparam logic [7:0] cOfsDiv = 8'h04;

	// Transmit byte
	localparam logic [7:0] cOfsTxd = 8'h08;

	// Chip select level, driven straight to the pin
	localparam logic [7:0] cOfsCs = 8'h0C;

	// Last received byte, read only
	localparam logic [7:0] cOfsRxd = 8'h80;

endpackage

//--- spi/spiCsr.sv
//--------------------
// Register block on the USI bus
// Writes are single-cycle strobes, no handshake
// Any address in this block returns a read one cycle later
// Unmapped offsets read as zero
// An end-of-transfer pulse wins over a write to enable
//--------------------
`timescale 1ns/1ps

module spiCsr
	import spiPkg::*;
#(
	parameter int                         pBlockAdrsWidth = 8,
	parameter logic [pBlockAdrsWidth-1:0] pAdrsMap        = 'h03,
	parameter int                         pCsrAdrsWidth   = 8,
	parameter int                         pUsiBusWidth    = 32,
	parameter int                         pDivClk         = 16
)(
	input  logic                     iSCLK,
	input  logic                     iSRST,
	// USI write side
	input  logic [cUsiDataWidth-1:0] iSUsiWd,
	input  logic [pUsiBusWidth-1:0]  iSUsiAdrs,
	input  logic                     iSUsiWCke,
	// USI read return
	output logic [cUsiDataWidth-1:0] oSUsiRd,
	output logic                     oSUsiREd,
	// From the sequencer and shifter
	input  logic                     spiIntr,
	input  logic [cDataWidth-1:0]    rxData,
	// Register outputs
	output logic                     spiEn,
	output logic [pDivClk-1:0]       spiDiv,
	output logic [cDataWidth-1:0]    txData,
	output logic                     spiCs
);

	//--------------------
	// Address decode
	//--------------------
	logic                     blockHit;
	logic [pCsrAdrsWidth-1:0] adrsOfs;
	logic                     wrEn;
	logic                     wrDiv;
	logic                     wrTxd;
	logic                     wrCs;
	// Receive byte, follows the shifter every cycle
	logic [cDataWidth-1:0]    rxReg;

	// Upper field selects this block
	assign blockHit = (iSUsiAdrs[pBlockAdrsWidth+pCsrAdrsWidth-1 -: pBlockAdrsWidth] == pAdrsMap);
	assign adrsOfs  = iSUsiAdrs[pCsrAdrsWidth-1:0];

	// Per-register write strobes
	assign wrEn  = iSUsiWCke & blockHit & (adrsOfs == pCsrAdrsWidth'(cOfsEn));
	assign wrDiv = iSUsiWCke & blockHit & (adrsOfs == pCsrAdrsWidth'(cOfsDiv));
	assign wrTxd = iSUsiWCke & blockHit & (adrsOfs == pCsrAdrsWidth'(cOfsTxd));
	assign wrCs  = iSUsiWCke & blockHit & (adrsOfs == pCsrAdrsWidth'(cOfsCs));

	//--------------------
	// Write registers
	//--------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			spiEn  <= 1'b0;
			// Slowest SCK until software sets a divider
			spiDiv <= '1;
			txData <= '0;
			// CS idles deasserted
			spiCs  <= 1'b1;
		end
		else
		begin
			// Interrupt clears enable first
			if (spiIntr)
				spiEn <= 1'b0;
			else if (wrEn)
				spiEn <= iSUsiWd[0];
			if (wrDiv)
				spiDiv <= iSUsiWd[pDivClk-1:0];
			if (wrTxd)
				txData <= iSUsiWd[cDataWidth-1:0];
			if (wrCs)
				spiCs <= iSUsiWd[0];
		end
	end

	// Capture of the shifter output
	always_ff @(posedge iSCLK)
	begin
		rxReg <= rxData;
	end

	//--------------------
	// Read return
	//--------------------
	// Valid strobe one cycle after a block hit
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
			oSUsiREd <= 1'b0;
		else
			oSUsiREd <= blockHit;
	end

	// Read data, zero extended to the bus word
	always_ff @(posedge iSCLK)
	begin
		if (blockHit)
		begin
			case (adrsOfs)
				pCsrAdrsWidth'(cOfsEn):  oSUsiRd <= cUsiDataWidth'(spiEn);
				pCsrAdrsWidth'(cOfsDiv): oSUsiRd <= cUsiDataWidth'(spiDiv);
				pCsrAdrsWidth'(cOfsTxd): oSUsiRd <= cUsiDataWidth'(txData);
				pCsrAdrsWidth'(cOfsCs):  oSUsiRd <= cUsiDataWidth'(spiCs);
				pCsrAdrsWidth'(cOfsRxd): oSUsiRd <= cUsiDataWidth'(rxReg);
				// Hole in the map
				default:                 oSUsiRd <= '0;
			endcase
		end
	end

endmodule

//--- spi/spiSequencer.sv
//--------------------
// Transfer control for one 8-bit mode-0 frame
// Starts on the rising edge of enable only
// Adds one load and one done cycle around the SCK run
//--------------------
`timescale 1ns/1ps

module spiSequencer
	import spiPkg::*;
(
	input  logic iSCLK,
	input  logic iSRST,
	input  logic spiEn,
	input  logic sckRise,
	input  logic sckFall,
	output logic clkRun,
	output logic shLoad,
	output logic spiIntr
);

	//--------------------
	// State encoding
	//--------------------
	localparam logic [1:0] stIdle  = 2'd0;
	localparam logic [1:0] stLoad  = 2'd1;
	localparam logic [1:0] stShift = 2'd2;
	localparam logic [1:0] stDone  = 2'd3;

	logic [1:0]              state;
	// Enable delayed by one cycle for edge detect
	logic                    spiEnD;
	logic                    startReq;
	// Rising edges seen so far
	logic [cBitCntWidth-1:0] bitCnt;
	// Set once the eighth rise has gone by
	logic                    lastBit;

	assign startReq = spiEn & ~spiEnD;

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
			spiEnD <= 1'b0;
		else
			spiEnD <= spiEn;
	end

	//--------------------
	// FSM
	//--------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			state   <= stIdle;
			bitCnt  <= '0;
			lastBit <= 1'b0;
		end
		else
		begin
			case (state)
				stIdle:
				begin
					bitCnt  <= '0;
					lastBit <= 1'b0;
					if (startReq)
						state <= stLoad;
				end
				// Shifter takes the tx byte here
				stLoad:
					state <= stShift;
				stShift:
				begin
					if (sckRise)
					begin
						bitCnt  <= bitCnt + 1'b1;
						lastBit <= (bitCnt == '1);
					end
					// Falling edge after the last bit ends the frame
					if (sckFall && lastBit)
						state <= stDone;
				end
				default:
					state <= stIdle;
			endcase
		end
	end

	// Outputs decoded from state
	assign clkRun  = (state == stShift);
	assign shLoad  = (state == stLoad);
	// One-cycle pulse, also clears enable
	assign spiIntr = (state == stDone);

endmodule

//--- spi/spiClkGen.sv
//--------------------
// SCK generator, half period is divider plus one cycles
// Divider is latched while idle, so changes wait for the next frame
// Edge pulses are combinational and lead the SCK change
//--------------------
`timescale 1ns/1ps

module spiClkGen #(
	parameter int pDivClk = 16
)(
	input  logic               iSCLK,
	input  logic               iSRST,
	input  logic               clkRun,
	input  logic [pDivClk-1:0] spiDiv,
	output logic               sckRise,
	output logic               sckFall,
	output logic               oSpiSck
);

	//--------------------
	// Divider counter
	//--------------------
	logic [pDivClk-1:0] divCnt;
	// Divider held for the whole frame
	logic [pDivClk-1:0] divLatch;
	logic               sckReg;
	logic               cntExpire;

	assign cntExpire = clkRun & (divCnt == '0);

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			divCnt   <= '1;
			divLatch <= '1;
			sckReg   <= 1'b0;
		end
		else if (!clkRun)
		begin
			// Idle, park SCK low and track the register
			divCnt   <= spiDiv;
			divLatch <= spiDiv;
			sckReg   <= 1'b0;
		end
		else if (cntExpire)
		begin
			sckReg <= ~sckReg;
			divCnt <= divLatch;
		end
		else
			divCnt <= divCnt - 1'b1;
	end

	// Edge pulses, one cycle ahead of the pin
	assign sckRise = cntExpire & ~sckReg;
	assign sckFall = cntExpire & sckReg;
	assign oSpiSck = sckReg;

endmodule

//--- spi/spiShifter.sv
//--------------------
// MOSI and MISO shift registers, MSB first
// Loaded by the sequencer, stepped by the SCK edge pulses
// MOSI idles low once all bits have shifted out
//--------------------
`timescale 1ns/1ps

module spiShifter
	import spiPkg::*;
(
	input  logic                  iSCLK,
	input  logic                  iSRST,
	input  logic                  shLoad,
	input  logic                  sckRise,
	input  logic                  sckFall,
	input  logic [cDataWidth-1:0] txData,
	input  logic                  iSpiMiso,
	output logic                  oSpiMosi,
	output logic [cDataWidth-1:0] rxData
);

	//--------------------
	// Transmit side
	//--------------------
	logic [cDataWidth-1:0] txShift;
	logic [cDataWidth-1:0] rxShift;

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
			txShift <= '0;
		else if (shLoad)
			txShift <= txData;
		else if (sckFall)
			// Next bit out, zero fill behind it
			txShift <= {txShift[cDataWidth-2:0], 1'b0};
	end

	// MSB is always on the pin
	assign oSpiMosi = txShift[cDataWidth-1];

	//--------------------
	// Receive side
	//--------------------
	// Sample just before SCK rises, MISO is stable then
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
			rxShift <= '0;
		else if (sckRise)
			rxShift <= {rxShift[cDataWidth-2:0], iSpiMiso};
	end

	assign rxData = rxShift;

endmodule

//--- logic/spiHost.sv
//--------------------
// SPI master top, USI register bus to SPI pins
// CS is software driven through its register
// One byte per enable write, mode 0 only
//--------------------
`timescale 1ns/1ps

module spiHost
	import spiPkg::*;
#(
	parameter int                         pBlockAdrsWidth = 8,
	parameter logic [pBlockAdrsWidth-1:0] pAdrsMap        = 'h03,
	parameter int                         pCsrAdrsWidth   = 8,
	parameter int                         pUsiBusWidth    = 32,
	parameter int                         pDivClk         = 16
)(
	input  logic                     iSCLK,
	input  logic                     iSRST,
	input  logic [cUsiDataWidth-1:0] iSUsiWd,
	input  logic [pUsiBusWidth-1:0]  iSUsiAdrs,
	input  logic                     iSUsiWCke,
	input  logic                     iSpiMiso,
	output logic [cUsiDataWidth-1:0] oSUsiRd,
	output logic                     oSUsiREd,
	output logic                     oSpiSck,
	output logic                     oSpiMosi,
	output logic                     oSpiCs,
	output logic                     oSpiIntr
);

	//--------------------
	// Internal wiring
	//--------------------
	logic                  spiEn;
	logic [pDivClk-1:0]    spiDiv;
	logic [cDataWidth-1:0] txData;
	logic [cDataWidth-1:0] rxData;
	logic                  spiIntr;
	logic                  clkRun;
	logic                  shLoad;
	logic                  sckRise;
	logic                  sckFall;

	// Registers and bus decode
	spiCsr #(
		.pBlockAdrsWidth (pBlockAdrsWidth),
		.pAdrsMap        (pAdrsMap),
		.pCsrAdrsWidth   (pCsrAdrsWidth),
		.pUsiBusWidth    (pUsiBusWidth),
		.pDivClk         (pDivClk)
	) u_spiCsr (
		.iSCLK     (iSCLK),
		.iSRST     (iSRST),
		.iSUsiWd   (iSUsiWd),
		.iSUsiAdrs (iSUsiAdrs),
		.iSUsiWCke (iSUsiWCke),
		.oSUsiRd   (oSUsiRd),
		.oSUsiREd  (oSUsiREd),
		.spiIntr   (spiIntr),
		.rxData    (rxData),
		.spiEn     (spiEn),
		.spiDiv    (spiDiv),
		.txData    (txData),
		.spiCs     (oSpiCs)
	);

	// Frame control
	spiSequencer u_spiSequencer (
		.iSCLK   (iSCLK),
		.iSRST   (iSRST),
		.spiEn   (spiEn),
		.sckRise (sckRise),
		.sckFall (sckFall),
		.clkRun  (clkRun),
		.shLoad  (shLoad),
		.spiIntr (spiIntr)
	);

	// SCK and its edge pulses
	spiClkGen #(
		.pDivClk (pDivClk)
	) u_spiClkGen (
		.iSCLK   (iSCLK),
		.iSRST   (iSRST),
		.clkRun  (clkRun),
		.spiDiv  (spiDiv),
		.sckRise (sckRise),
		.sckFall (sckFall),
		.oSpiSck (oSpiSck)
	);

	// Data path
	spiShifter u_spiShifter (
		.iSCLK    (iSCLK),
		.iSRST    (iSRST),
		.shLoad   (shLoad),
		.sckRise  (sckRise),
		.sckFall  (sckFall),
		.txData   (txData),
		.iSpiMiso (iSpiMiso),
		.oSpiMosi (oSpiMosi),
		.rxData   (rxData)
	);

	assign oSpiIntr = spiIntr;

endmodule

//--- dv/spiSlaveModel.sv
//--------------------
// Behavioral SPI mode-0 slave
// Frame starts when CS falls with SCK low
// MISO byte is latched at CS fall, MSB first
// Samples MOSI on SCK rise, moves MISO on SCK fall
//--------------------
`timescale 1ns/1ps

module spiSlaveModel
	import spiPkg::*;
(
	input  logic                  sck,
	input  logic                  mosi,
	input  logic                  cs,
	input  logic [cDataWidth-1:0] misoByte,
	output logic                  miso,
	output logic [cDataWidth-1:0] mosiByte,
	output int                    bitCount
);

	// Frame state, all owned by the one process below
	logic [cDataWidth-1:0] txHold  = '0;
	logic [cDataWidth-1:0] rxShift = '0;
	logic                  misoReg = 1'b0;
	logic                  csPrev  = 1'b1;
	logic                  sckPrev = 1'b0;
	int                    riseCnt = 0;

	//--------------------
	// Edge handling
	//--------------------
	// CS rise only updates csPrev, so the next fall opens a new frame
	always @(posedge sck or negedge sck or negedge cs or posedge cs)
	begin
		if (!cs && csPrev)
		begin
			// New frame, first bit out before the first rise
			riseCnt = 0;
			rxShift = '0;
			txHold  = misoByte;
			misoReg = misoByte[cDataWidth-1];
		end
		else if (!cs && sck && !sckPrev)
		begin
			rxShift = {rxShift[cDataWidth-2:0], mosi};
			riseCnt = riseCnt + 1;
		end
		else if (!cs && !sck && sckPrev)
		begin
			// Next bit for the following rise
			txHold  = {txHold[cDataWidth-2:0], 1'b0};
			misoReg = txHold[cDataWidth-1];
		end
		csPrev  = cs;
		sckPrev = sck;
	end

	assign miso     = misoReg;
	assign mosiByte = rxShift;
	assign bitCount = riseCnt;

endmodule

//--- dv/spiHostTb.sv
//--------------------
// Testbench for the SPI master on the USI bus
// Block select 0x03, wrong block 0x5A
// Dividers in transfers stay within 0 to 7
// Inputs change 10 ns after each rising clock edge
//--------------------
`timescale 1ns/1ps

module spiHostTb
	import spiPkg::*;
();

	//--------------------
	// Constants
	//--------------------
	localparam int         cClkPeriod  = 100;
	localparam int         cSeed       = 56338;
	localparam logic [7:0] cBlock      = 8'h03;
	localparam logic [7:0] cWrongBlock = 8'h5A;
	localparam int         cXferCount  = 15;
	localparam int         cMaxDiv     = 7;
	// Longest frame, SCK run plus load and done cycles
	localparam int         cXferCycles = 16 * (cMaxDiv + 1) + 2;
	localparam int         cWatchdog   = 20 * cXferCycles + 1000;

	// DUT inputs and outputs
	logic        iSCLK;
	logic        iSRST;
	logic [31:0] iSUsiWd;
	logic [31:0] iSUsiAdrs;
	logic        iSUsiWCke;
	logic        iSpiMiso;
	logic [31:0] oSUsiRd;
	logic        oSUsiREd;
	logic        oSpiSck;
	logic        oSpiMosi;
	logic        oSpiCs;
	logic        oSpiIntr;

	// Slave side
	logic [7:0] slaveMiso;
	logic [7:0] slaveMosi;
	int         slaveBits;

	// Register model
	logic        shEn;
	logic [15:0] shDiv;
	logic [7:0]  shTxd;
	logic        shCs;
	logic [7:0]  shRx;

	// Pending comparisons
	logic [31:0] gotQ[$];
	logic [31:0] expQ[$];
	string       tagQ[$];
	time         timeQ[$];

	int checkCount    = 0;
	int mismatchCount = 0;
	int otherErrCount = 0;
	int intrCount     = 0;

	// SCK half periods of the current frame
	int   halfQ[$];
	int   halfCnt = 0;
	logic sckSeen = 1'b0;
	logic inFrame = 1'b0;

	spiHost #(
		.pBlockAdrsWidth (8),
		.pAdrsMap        (cBlock),
		.pCsrAdrsWidth   (8),
		.pUsiBusWidth    (32),
		.pDivClk         (16)
	) u_spiHost (
		.iSCLK     (iSCLK),
		.iSRST     (iSRST),
		.iSUsiWd   (iSUsiWd),
		.iSUsiAdrs (iSUsiAdrs),
		.iSUsiWCke (iSUsiWCke),
		.iSpiMiso  (iSpiMiso),
		.oSUsiRd   (oSUsiRd),
		.oSUsiREd  (oSUsiREd),
		.oSpiSck   (oSpiSck),
		.oSpiMosi  (oSpiMosi),
		.oSpiCs    (oSpiCs),
		.oSpiIntr  (oSpiIntr)
	);

	spiSlaveModel u_spiSlaveModel (
		.sck      (oSpiSck),
		.mosi     (oSpiMosi),
		.cs       (oSpiCs),
		.misoByte (slaveMiso),
		.miso     (iSpiMiso),
		.mosiByte (slaveMosi),
		.bitCount (slaveBits)
	);

	initial
	begin
		iSCLK = 1'b0;
		forever #(cClkPeriod / 2) iSCLK = ~iSCLK;
	end

	//--------------------
	// Reference model
	//--------------------
	// Readback, zero extended from each register width
	function automatic logic [31:0] refRead(input logic [7:0] ofs);
		logic [31:0] value;
		case (ofs)
			cOfsEn:  value = {31'd0, shEn};
			cOfsDiv: value = {16'd0, shDiv};
			cOfsTxd: value = {24'd0, shTxd};
			cOfsCs:  value = {31'd0, shCs};
			cOfsRxd: value = {24'd0, shRx};
			default: value = 32'd0;
		endcase
		return value;
	endfunction

	// Byte as seen at the far end of the wire, MSB sent first
	function automatic logic [7:0] refWire(input logic [7:0] sent);
		logic [7:0] acc;
		logic [7:0] line;
		acc  = 8'd0;
		line = sent;
		for (int i = 0; i < 8; i++)
		begin
			acc  = {acc[6:0], line[7]};
			line = {line[6:0], 1'b0};
		end
		return acc;
	endfunction

	//--------------------
	// Monitors
	//--------------------
	always @(posedge iSCLK)
	begin
		if (oSpiIntr === 1'b1)
			intrCount++;
	end

	// Cycles between SCK toggles inside one frame
	always @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			inFrame = 1'b0;
			halfCnt = 0;
		end
		else if (oSpiSck !== sckSeen)
		begin
			if (inFrame)
				halfQ.push_back(halfCnt);
			inFrame = 1'b1;
			halfCnt = 1;
		end
		else
			halfCnt++;
		// Frame over once the interrupt shows
		if (oSpiIntr === 1'b1)
			inFrame = 1'b0;
		sckSeen = oSpiSck;
	end

	// Compare process, drains queued results each cycle
	always @(posedge iSCLK)
	begin : compareProc
		logic [31:0] got;
		logic [31:0] expv;
		string       tag;
		time         when;
		while (gotQ.size() > 0)
		begin
			got  = gotQ.pop_front();
			expv = expQ.pop_front();
			tag  = tagQ.pop_front();
			when = timeQ.pop_front();
			checkCount++;
			assert (got === expv)
			else
			begin
				mismatchCount++;
				$display("mismatch at %0t: %s, got 0x%0h, expected 0x%0h",
					when, tag, got, expv);
			end
		end
	end

	//--------------------
	// Bus tasks
	//--------------------
	task automatic postCheck(input logic [31:0] got, input logic [31:0] expv,
		input string tag);
		gotQ.push_back(got);
		expQ.push_back(expv);
		tagQ.push_back(tag);
		timeQ.push_back($time);
	endtask

	task automatic busWrite(input logic [7:0] blk, input logic [7:0] ofs,
		input logic [31:0] data);
		iSUsiAdrs = {16'h0000, blk, ofs};
		iSUsiWd   = data;
		iSUsiWCke = 1'b1;
		@(posedge iSCLK);
		#10;
		iSUsiWCke = 1'b0;
		iSUsiAdrs = 32'd0;
		iSUsiWd   = 32'd0;
	endtask

	// Exactly one cycle to the read strobe
	task automatic busRead(input logic [7:0] blk, input logic [7:0] ofs,
		output logic [31:0] data, output logic ack);
		iSUsiAdrs = {16'h0000, blk, ofs};
		@(posedge iSCLK);
		#10;
		iSUsiAdrs = 32'd0;
		ack  = oSUsiREd;
		data = oSUsiRd;
	endtask

	// Write through the model as well as the DUT
	task automatic regWrite(input logic [7:0] ofs, input logic [31:0] data);
		case (ofs)
			cOfsEn:  shEn  = data[0];
			cOfsDiv: shDiv = data[15:0];
			cOfsTxd: shTxd = data[7:0];
			cOfsCs:  shCs  = data[0];
			default: ;
		endcase
		busWrite(cBlock, ofs, data);
		if (ofs == cOfsCs)
			postCheck(32'(oSpiCs), 32'(shCs), "CS pin after CS write");
	endtask

	task automatic checkRead(input logic [7:0] ofs, input string tag);
		logic [31:0] data;
		logic        ack;
		busRead(cBlock, ofs, data, ack);
		postCheck(32'(ack), 32'd1, {tag, " read strobe"});
		postCheck(data, refRead(ofs), tag);
	endtask

	// One frame, optionally with a divider write while it runs
	task automatic runTransfer(input logic [15:0] div, input logic [7:0] tx,
		input logic [7:0] rx, input bit midWrite);
		int beforeIntr;
		int limit;
		int waited;
		slaveMiso = rx;
		regWrite(cOfsDiv, {16'd0, div});
		regWrite(cOfsTxd, {24'd0, tx});
		regWrite(cOfsCs, 32'd0);
		beforeIntr = intrCount;
		halfQ.delete();
		regWrite(cOfsEn, 32'd1);
		if (midWrite)
		begin
			repeat (3) @(posedge iSCLK);
			#10;
			regWrite(cOfsDiv, $urandom());
		end
		limit  = 16 * (int'(div) + 1) + 16;
		waited = 0;
		while (intrCount == beforeIntr && waited < limit)
		begin
			@(posedge iSCLK);
			waited++;
		end
		#10;
		if (intrCount == beforeIntr)
		begin
			otherErrCount++;
			$display("Transfer with divider %0d never raised its interrupt", div);
		end
		// A second pulse would show up here
		repeat (4) @(posedge iSCLK);
		#10;
		shEn = 1'b0;
		shRx = refWire(rx);
		postCheck(32'(intrCount - beforeIntr), 32'd1, "interrupt pulses per frame");
		postCheck(32'(slaveBits), 32'd8, "bits seen by slave");
		postCheck({24'd0, slaveMosi}, {24'd0, refWire(tx)}, "MOSI byte at slave");
		postCheck(32'(halfQ.size()), 32'd15, "SCK half periods per frame");
		foreach (halfQ[k])
			postCheck(32'(halfQ[k]), 32'(int'(div) + 1), "SCK half period length");
		checkRead(cOfsRxd, "receive register");
		checkRead(cOfsEn, "enable after frame");
		regWrite(cOfsCs, 32'd1);
	endtask

	//--------------------
	// Stimulus
	//--------------------
	initial
	begin : stimulus
		logic [7:0]  ofsSel;
		logic [31:0] data;
		logic        ack;
		logic [7:0]  holes[5];
		iSRST     = 1'b1;
		iSUsiWd   = 32'd0;
		iSUsiAdrs = 32'd0;
		iSUsiWCke = 1'b0;
		slaveMiso = 8'd0;
		shEn      = 1'b0;
		shDiv     = 16'hFFFF;
		shTxd     = 8'd0;
		shCs      = 1'b1;
		shRx      = 8'd0;
		holes     = '{8'h10, 8'h44, 8'h7C, 8'h81, 8'hFC};
		void'($urandom(cSeed));
		repeat (4) @(posedge iSCLK);
		#10;
		iSRST = 1'b0;

		// Reset values
		postCheck(32'(oSpiCs), 32'd1, "CS pin after reset");
		postCheck(32'(oSpiSck), 32'd0, "SCK pin after reset");
		postCheck(32'(oSpiMosi), 32'd0, "MOSI pin after reset");
		checkRead(cOfsEn, "enable after reset");
		checkRead(cOfsDiv, "divider after reset");
		checkRead(cOfsTxd, "transmit after reset");
		checkRead(cOfsCs, "CS after reset");
		checkRead(cOfsRxd, "receive after reset");
		postCheck(32'(intrCount), 32'd0, "interrupts after reset");

		// Random register traffic
		for (int i = 0; i < 12; i++)
		begin
			case ($urandom_range(2, 0))
				0:       ofsSel = cOfsDiv;
				1:       ofsSel = cOfsTxd;
				default: ofsSel = cOfsCs;
			endcase
			regWrite(ofsSel, $urandom());
			checkRead(ofsSel, "random register readback");
		end
		foreach (holes[k])
			checkRead(holes[k], "unmapped offset");

		// Wrong block field is ignored
		busWrite(cWrongBlock, cOfsDiv, $urandom());
		busWrite(cWrongBlock, cOfsTxd, $urandom());
		busWrite(cWrongBlock, cOfsCs, $urandom());
		checkRead(cOfsDiv, "divider after foreign write");
		checkRead(cOfsTxd, "transmit after foreign write");
		checkRead(cOfsCs, "CS after foreign write");
		postCheck(32'(oSpiCs), 32'(shCs), "CS pin after foreign write");
		busRead(cWrongBlock, cOfsDiv, data, ack);
		postCheck(32'(ack), 32'd0, "read strobe for foreign block");
		regWrite(cOfsCs, 32'd1);

		// Frames with random divider, tx and rx bytes
		for (int i = 0; i < cXferCount; i++)
			runTransfer(16'($urandom_range(cMaxDiv, 0)), 8'($urandom()),
				8'($urandom()), (i % 3) == 1);

		while (gotQ.size() != 0)
			@(posedge iSCLK);
		$display("Checks: %0d compared, %0d mismatches, %0d other errors",
			checkCount, mismatchCount, otherErrCount);
		if (mismatchCount == 0 && otherErrCount == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	// Watchdog, sized from the longest frames plus slack
	initial
	begin
		#(cWatchdog * cClkPeriod);
		$display("Watchdog expired after %0d cycles, the run did not complete", cWatchdog);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

//--- spiHost.f
common/spiPkg.sv
spi/spiCsr.sv
spi/spiSequencer.sv
spi/spiClkGen.sv
spi/spiShifter.sv
logic/spiHost.sv
dv/spiSlaveModel.sv
dv/spiHostTb.sv

//--- runSim.sh
#!/bin/sh
# Build and run the spiHost testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module spiHostTb -f spiHost.f
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/VspiHostTb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "RESULT: PASS"; then
	exit 0
fi
exit 1
